// ==== list.f ====
logic/rtc_pkg.sv
logic/rtc_read_sequencer.sv
logic/rtc_bus_cycle.sv
logic/rtc_shadow_regs.sv
logic/rtc_reader_top.sv
sim/rtc_chip_model.sv
sim/tb_rtc_reader.sv

// ==== Bender.yml ====
package:
  name: rtc_reader

sources:
  - logic/rtc_pkg.sv
  - logic/rtc_read_sequencer.sv
  - logic/rtc_bus_cycle.sv
  - logic/rtc_shadow_regs.sv
  - logic/rtc_reader_top.sv
  - target: simulation
    files:
      - sim/rtc_chip_model.sv
      - sim/tb_rtc_reader.sv

// ==== sim/tb_rtc_reader.sv ====
module tb_rtc_reader;

  timeunit 1ns;
  timeprecision 1ps;

  import rtc_pkg::*;

  // Request to done for the command and every read
  localparam int pass_cycles = (num_reads + 1) * 4 * phase_cycles;
  localparam int cycle_limit = 3 * pass_cycles + 200;

  logic                   clk;
  logic                   reset;
  logic                   start;
  logic [reg_index_w-1:0] rd_index;
  logic [7:0]             rd_data;
  logic                   snapshot_valid;
  logic                   busy;
  logic                   refresh_done;
  logic                   cs_n;
  logic                   as_n;
  logic                   rd_n;
  logic                   wr_n;
  logic                   ad_oe;
  logic [7:0]             ad_out;
  logic [7:0]             ad_in;
  int                     cmd_writes;
  int                     reads_seen;
  int                     bad_accesses;

  logic [15:0] lfsr_state;
  logic [7:0]  expected [num_reads];
  logic [7:0]  previous [num_reads];
  int          test_errors = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycles = 0;

  rtc_reader_top uut (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .rd_index       (rd_index),
    .rd_data        (rd_data),
    .snapshot_valid (snapshot_valid),
    .busy           (busy),
    .refresh_done   (refresh_done),
    .cs_n           (cs_n),
    .as_n           (as_n),
    .rd_n           (rd_n),
    .wr_n           (wr_n),
    .ad_oe          (ad_oe),
    .ad_out         (ad_out),
    .ad_in          (ad_in)
  );

  rtc_chip_model chip (
    .clk          (clk),
    .reset        (reset),
    .cs_n         (cs_n),
    .as_n         (as_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .ad_oe        (ad_oe),
    .ad_out       (ad_out),
    .ad_in        (ad_in),
    .cmd_writes   (cmd_writes),
    .reads_seen   (reads_seen),
    .bad_accesses (bad_accesses)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a refresh never finished", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      b          = {b[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // New live values, last pass kept for the coherence check
  task automatic load_live();
    logic [7:0] v;
    for (int i = 0; i < num_reads; i++) begin
      random_byte(v);
      previous[i]                 = expected[i];
      expected[i]                 = v;
      chip.live[read_addr_table[i]] = v;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp)
      else begin
        $display("ERROR %s: expected %h actual %h", name, exp, act);
        test_errors++;
      end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1)
      else begin
        $display("%s", msg);
        test_errors++;
      end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s with %0d errors", name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_refresh();
    do @(negedge clk); while (!refresh_done);
  endtask

  task automatic read_snapshot(input string name);
    for (int i = 0; i < num_reads; i++) begin
      @(negedge clk);
      rd_index = read_index_table[i];
      @(negedge clk);
      check_byte(name, expected[i], rd_data);
    end
  endtask

  // Old bank must hold through the pass, a second start lands mid-pass
  task automatic coherence_pass();
    int  j;
    int  k;
    logic seen_done;
    j         = 0;
    k         = 0;
    seen_done = 1'b0;
    @(negedge clk);
    start    = 1'b1;
    rd_index = read_index_table[0];
    @(negedge clk);
    start = 1'b0;
    while (!seen_done) begin
      @(negedge clk);
      k++;
      check_byte("snapshot_coherence", previous[j], rd_data);
      seen_done = refresh_done;
      start     = (k == 20);
      j         = (j + 1) % num_reads;
      rd_index  = read_index_table[j];
    end
    @(negedge clk);
    start = 1'b0;
    check_byte("snapshot_coherence", expected[j], rd_data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    start      = 1'b0;
    rd_index   = '0;
    lfsr_state = 16'd64;
    for (int i = 0; i < num_reads; i++) begin
      expected[i] = 8'h00;
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;

    check_true(cs_n && as_n && rd_n && wr_n, "Chip strobes not idle after reset");
    check_true(!ad_oe && !busy && !snapshot_valid, "Bus drive or status high after reset");
    finish_test("reset_state");

    load_live();
    pulse_start();
    wait_refresh();
    @(negedge clk);
    check_true(cmd_writes == 1 && reads_seen == num_reads,
               "First pass did not make one command write and nine reads");
    finish_test("access_order");
    check_true(snapshot_valid, "snapshot_valid not set after the first refresh");
    read_snapshot("first_snapshot");
    finish_test("first_snapshot");

    load_live();
    coherence_pass();
    finish_test("snapshot_coherence");
    repeat (4) @(negedge clk);
    check_true(cmd_writes == 2 && !busy, "A start during a pass launched another pass");
    finish_test("start_while_busy");
    read_snapshot("second_snapshot");
    finish_test("second_snapshot");

    check_true(bad_accesses == 0, "Chip model reported bus protocol or access errors");
    finish_test("bus_protocol");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== sim/rtc_chip_model.sv ====
module rtc_chip_model (
  input  logic       clk,
  input  logic       reset,
  input  logic       cs_n,
  input  logic       as_n,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       ad_oe,
  input  logic [7:0] ad_out,
  output logic [7:0] ad_in,
  output int         cmd_writes,
  output int         reads_seen,
  output int         bad_accesses
);

  timeunit 1ns;
  timeprecision 1ps;

  import rtc_pkg::*;

  // Running counters, loaded by the testbench
  logic [7:0] live [256];
  // Copy taken by the transfer command, what reads return
  logic [7:0] frozen [256];

  logic [7:0] addr_q;
  logic       rd_n_q;
  logic       wr_n_q;
  int         proto_errors = 0;
  int         order_errors = 0;

  initial begin
    for (int i = 0; i < 256; i++) begin
      live[i]   = 8'h00;
      frozen[i] = 8'h00;
    end
  end

  assign ad_in        = rd_n ? 8'h00 : frozen[addr_q];
  assign bad_accesses = proto_errors + order_errors;

  ////////////////////////////////////////////////////////////////////////////
  // Address latch and access tracking
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      addr_q     <= 8'h00;
      rd_n_q     <= 1'b1;
      wr_n_q     <= 1'b1;
      cmd_writes <= 0;
      reads_seen <= 0;
    end else begin
      rd_n_q <= rd_n;
      wr_n_q <= wr_n;
      if (!as_n) begin
        addr_q <= ad_out;
      end
      // First clock of a write data phase
      if (!wr_n && wr_n_q) begin
        if (addr_q == cmd_addr && ad_out == 8'h00) begin
          cmd_writes <= cmd_writes + 1;
          reads_seen <= 0;
          for (int i = 0; i < 256; i++) begin
            frozen[i] <= live[i];
          end
        end else begin
          $display("Chip model saw a write of %h to address %h", ad_out, addr_q);
          order_errors++;
        end
      end
      // First clock of a read data phase, table order expected
      if (!rd_n && rd_n_q) begin
        if (reads_seen >= num_reads || addr_q != read_addr_table[reads_seen]) begin
          $display("Chip model saw read %0d at address %h out of order", reads_seen, addr_q);
          order_errors++;
        end
        reads_seen <= reads_seen + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (reset) !(!rd_n && !wr_n))
    else begin
      $display("Chip model saw rd_n and wr_n low together");
      proto_errors++;
    end

  assert property (@(posedge clk) disable iff (reset) !((!rd_n || !wr_n) && !as_n))
    else begin
      $display("Chip model saw a data strobe during the address strobe");
      proto_errors++;
    end

  assert property (@(posedge clk) disable iff (reset) (!as_n || !rd_n || !wr_n) |-> !cs_n)
    else begin
      $display("Chip model saw a strobe without chip select");
      proto_errors++;
    end

  // Chip drives the bus during a read
  assert property (@(posedge clk) disable iff (reset) !rd_n |-> !ad_oe)
    else begin
      $display("Chip model saw the host driving the bus during a read");
      proto_errors++;
    end

endmodule

// ==== logic/rtc_reader_top.sv ====
module rtc_reader_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic [rtc_pkg::reg_index_w-1:0] rd_index,
  output logic [7:0]                    rd_data,
  output logic                          snapshot_valid,
  output logic                          busy,
  output logic                          refresh_done,
  output logic                          cs_n,
  output logic                          as_n,
  output logic                          rd_n,
  output logic                          wr_n,
  output logic                          ad_oe,
  output logic [7:0]                    ad_out,
  input  logic [7:0]                    ad_in
);

  import rtc_pkg::*;

  // Sequencer to bus controller
  logic [7:0] addr;
  logic [7:0] wdata;
  logic       bus_write;
  logic       bus_read;
  logic       done;

  // Bus controller and sequencer to shadow registers
  logic                   rdata_valid;
  logic [7:0]             rdata;
  logic [reg_index_w-1:0] reg_index;

  rtc_read_sequencer u_sequencer (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .done         (done),
    .addr         (addr),
    .wdata        (wdata),
    .reg_index    (reg_index),
    .bus_write    (bus_write),
    .bus_read     (bus_read),
    .busy         (busy),
    .refresh_done (refresh_done)
  );

  rtc_bus_cycle u_bus_cycle (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .wdata       (wdata),
    .bus_write   (bus_write),
    .bus_read    (bus_read),
    .done        (done),
    .rdata_valid (rdata_valid),
    .rdata       (rdata),
    .cs_n        (cs_n),
    .as_n        (as_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .ad_oe       (ad_oe),
    .ad_out      (ad_out),
    .ad_in       (ad_in)
  );

  rtc_shadow_regs u_shadow_regs (
    .clk            (clk),
    .reset          (reset),
    .wr_en          (rdata_valid),
    .wr_index       (reg_index),
    .wr_data        (rdata),
    .commit         (refresh_done),
    .rd_index       (rd_index),
    .rd_data        (rd_data),
    .snapshot_valid (snapshot_valid)
  );

endmodule

// ==== logic/rtc_shadow_regs.sv ====
module rtc_shadow_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr_en,
  input  logic [rtc_pkg::reg_index_w-1:0] wr_index,
  input  logic [7:0]                    wr_data,
  input  logic                          commit,
  input  logic [rtc_pkg::reg_index_w-1:0] rd_index,
  output logic [7:0]                    rd_data,
  output logic                          snapshot_valid
);

  import rtc_pkg::*;

  // Staging bank filled during a pass and visible bank seen by the host
  logic [7:0] staging [shadow_depth];
  logic [7:0] visible [shadow_depth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < shadow_depth; i++) begin
        staging[i] <= '0;
        visible[i] <= '0;
      end
      snapshot_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        staging[wr_index] <= wr_data;
      end
      // Whole-bank copy so the host never sees a partial pass
      if (commit) begin
        for (int i = 0; i < shadow_depth; i++) begin
          visible[i] <= staging[i];
        end
        snapshot_valid <= 1'b1;
      end
    end
  end

  assign rd_data = visible[rd_index];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Last staging write must land before the copy
  assert property (@(posedge clk) disable iff (reset)
    !(commit && wr_en))
    else $error("commit and wr_en in the same cycle");

endmodule

// ==== logic/rtc_bus_cycle.sv ====
module rtc_bus_cycle (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] addr,
  input  logic [7:0] wdata,
  input  logic       bus_write,
  input  logic       bus_read,
  output logic       done,
  output logic       rdata_valid,
  output logic [7:0] rdata,
  output logic       cs_n,
  output logic       as_n,
  output logic       rd_n,
  output logic       wr_n,
  output logic       ad_oe,
  output logic [7:0] ad_out,
  input  logic [7:0] ad_in
);

  import rtc_pkg::*;

  logic                   active;
  logic                   is_write;
  logic [1:0]             phase;
  logic [phase_cnt_w-1:0] cycle_cnt;
  logic                   phase_end;
  logic                   in_data;

  assign phase_end = (cycle_cnt == phase_cnt_w'(phase_cycles - 1));
  assign in_data   = active && (phase == ph_data);

  ////////////////////////////////////////////////////////////////////////////
  // Phase and cycle counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      active    <= 1'b0;
      is_write  <= 1'b0;
      phase     <= ph_addr_setup;
      cycle_cnt <= '0;
    end else if (!active) begin
      // Idle, wait for a request pulse
      if (bus_write || bus_read) begin
        active    <= 1'b1;
        is_write  <= bus_write;
        phase     <= ph_addr_setup;
        cycle_cnt <= '0;
      end
    end else if (phase_end) begin
      cycle_cnt <= '0;
      phase     <= phase + 2'd1;
      if (phase == ph_release) begin
        active <= 1'b0;
      end
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // Read data sampled on the last data-phase clock
  always_ff @(posedge clk) begin
    if (in_data && phase_end && !is_write) begin
      rdata <= ad_in;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Chip strobes and bus drive
  ////////////////////////////////////////////////////////////////////////////

  // Chip select covers setup, strobe and data, released in the last phase
  assign cs_n = !(active && (phase != ph_release));
  assign as_n = !(active && (phase == ph_addr_strobe));
  assign rd_n = !(in_data && !is_write);
  assign wr_n = !(in_data && is_write);

  // Address driven ahead of and through the strobe, write data in data phase
  assign ad_oe = active && ((phase == ph_addr_setup) ||
                            (phase == ph_addr_strobe) ||
                            (phase == ph_data && is_write));
  assign ad_out = (phase == ph_data) ? wdata : addr;

  // End of the release phase closes the cycle
  assign done        = active && (phase == ph_release) && phase_end;
  assign rdata_valid = done && !is_write;

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (reset)
    !(!rd_n && !wr_n))
    else $error("rd_n and wr_n low together");

  // Sequencer must wait for done before the next request
  assert property (@(posedge clk) disable iff (reset)
    (bus_write || bus_read) |-> !active)
    else $error("request while a bus cycle is in progress");

  // Request to done is four full phases
  assert property (@(posedge clk) disable iff (reset)
    (!active && (bus_write || bus_read)) |-> ##(4 * phase_cycles) done)
    else $error("bus cycle length wrong");

endmodule

// ==== logic/rtc_read_sequencer.sv ====
module rtc_read_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          done,
  output logic [7:0]                    addr,
  output logic [7:0]                    wdata,
  output logic [rtc_pkg::reg_index_w-1:0] reg_index,
  output logic                          bus_write,
  output logic                          bus_read,
  output logic                          busy,
  output logic                          refresh_done
);

  import rtc_pkg::*;

  logic [1:0]            state;
  logic [read_cnt_w-1:0] read_cnt;
  logic [read_cnt_w-1:0] next_cnt;
  logic                  last_read;

  assign next_cnt  = read_cnt + 1'b1;
  assign last_read = (read_cnt == read_cnt_w'(num_reads - 1));

  // Status straight from the state register
  assign busy         = (state != seq_idle);
  assign refresh_done = (state == seq_finish);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= seq_idle;
      read_cnt  <= '0;
      addr      <= '0;
      wdata     <= '0;
      reg_index <= '0;
      bus_write <= 1'b0;
      bus_read  <= 1'b0;
    end else begin
      // Requests are single-cycle pulses
      bus_write <= 1'b0;
      bus_read  <= 1'b0;

      case (state)
        seq_idle: begin
          if (start) begin
            state     <= seq_command;
            addr      <= cmd_addr;
            wdata     <= cmd_data;
            reg_index <= '0;
            bus_write <= 1'b1;
          end
        end

        seq_command: begin
          // Chip counters are frozen now so the first table read goes out
          if (done) begin
            state     <= seq_read;
            read_cnt  <= '0;
            addr      <= read_addr_table[0];
            reg_index <= read_index_table[0];
            bus_read  <= 1'b1;
          end
        end

        seq_read: begin
          if (done) begin
            if (last_read) begin
              state <= seq_finish;
            end else begin
              read_cnt  <= next_cnt;
              addr      <= read_addr_table[next_cnt];
              reg_index <= read_index_table[next_cnt];
              bus_read  <= 1'b1;
            end
          end
        end

        seq_finish: begin
          // Shadow bank commits during this single cycle
          state    <= seq_idle;
          read_cnt <= '0;
        end

        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // One request kind at a time towards the bus controller
  assert property (@(posedge clk) disable iff (reset)
    !(bus_write && bus_read))
    else $error("bus_write and bus_read high together");

  // A start during a pass must not launch another command write
  assert property (@(posedge clk) disable iff (reset)
    (start && busy) |=> !bus_write)
    else $error("start acted on while busy");

endmodule

// ==== logic/rtc_pkg.sv ====
package rtc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus cycle timing
  ////////////////////////////////////////////////////////////////////////////

  // Clocks per bus phase
  localparam int phase_cycles = 4;
  localparam int phase_cnt_w  = $clog2(phase_cycles);

  // Phase codes, in the order a cycle walks through them
  localparam logic [1:0] ph_addr_setup  = 2'd0;
  localparam logic [1:0] ph_addr_strobe = 2'd1;
  localparam logic [1:0] ph_data        = 2'd2;
  localparam logic [1:0] ph_release     = 2'd3;

  ////////////////////////////////////////////////////////////////////////////
  // Chip register map
  ////////////////////////////////////////////////////////////////////////////

  // Transfer command, freezes the counters into the read registers
  localparam logic [7:0] cmd_addr = 8'hF0;
  localparam logic [7:0] cmd_data = 8'h00;

  localparam int num_reads  = 9;
  localparam int read_cnt_w = $clog2(num_reads);

  // Clock secs, mins, hours, day, month, year, then timer secs, mins, hours
  localparam logic [7:0] read_addr_table [num_reads] = '{
    8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26,
    8'h41, 8'h42, 8'h43
  };

  ////////////////////////////////////////////////////////////////////////////
  // Shadow register file
  ////////////////////////////////////////////////////////////////////////////

  localparam int shadow_depth = 16;
  localparam int reg_index_w  = 4;

  // Shadow slot for each entry of read_addr_table
  localparam logic [reg_index_w-1:0] read_index_table [num_reads] = '{
    4'd1, 4'd2, 4'd3, 4'd12, 4'd13, 4'd14,
    4'd9, 4'd10, 4'd11
  };

  ////////////////////////////////////////////////////////////////////////////
  // Read sequencer states
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] seq_idle    = 2'd0;
  localparam logic [1:0] seq_command = 2'd1;
  localparam logic [1:0] seq_read    = 2'd2;
  localparam logic [1:0] seq_finish  = 2'd3;

endpackage
